// ==== files.f ====
+incdir+verilog
verilog/dma_pkg.sv
verilog/dma_chn_req.sv
verilog/dma_chn_arb.sv
verilog/dma_tlp_tx.sv
verilog/dma_rd_top.sv
test/dma_rd_assertions.sv
test/dma_rd_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dma read testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module dma_rd_tb \
    -o dma_rd_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/dma_rd_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== test/dma_rd_assertions.sv ====
/* read request stream checker */
`include "dma_config.svh"

module dma_rd_assertions
    import dma_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        chn0_desc_valid,
    input addr_t       chn0_desc_addr,
    input len_t        chn0_desc_len,
    input logic        chn0_busy,
    input logic        chn1_desc_valid,
    input addr_t       chn1_desc_addr,
    input len_t        chn1_desc_len,
    input logic        chn1_busy,
    input logic [31:0] tx_data,
    input logic        tx_valid,
    input logic        tx_sof,
    input logic        tx_eof
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;   // polled by the testbench

    addr_t      sh_addr [2];     // next expected address per channel
    len_t       sh_len [2];      // remaining dwords per channel
    addr_t      tl_addr [2];     // last chunk still on the wire
    len_t       tl_len [2];
    logic [1:0] tl_pend;
    logic [1:0] work_now;
    logic [1:0] work_after;      // work left once this tlp is counted
    logic [1:0] skip [2];        // tlps sent while channel waited
    logic [1:0] pos;             // dword index inside a tlp
    len_t       cur_len;
    len_t       exp_len;
    addr_t      exp_addr;
    chn_t       cur_chn;
    chn_t       last_chn;
    tag_t       exp_tag;
    logic       last_diff;       // last two grants alternated
    logic       both_last;       // both had work at previous eof
    logic       both_prev;       // both had work at the eof before that
    logic [1:0] n_tlp;           // saturates at 2
    logic       d_val [2];
    logic       d_busy [2];
    addr_t      d_addr [2];
    len_t       d_len [2];

    assign d_val  = '{chn0_desc_valid, chn1_desc_valid};
    assign d_busy = '{chn0_busy, chn1_busy};
    assign d_addr = '{chn0_desc_addr, chn1_desc_addr};
    assign d_len  = '{chn0_desc_len, chn1_desc_len};

    // counts a failure for the testbench and reports it
    task automatic flag_error(input string msg);
        fail_cnt++;
        $error("%s", msg);
    endtask

    //////////////////////////////////////////////////
    // expected values
    //////////////////////////////////////////////////

    always_comb begin
        len_t sel;
        sel      = tl_pend[cur_chn] ? tl_len[cur_chn] : sh_len[cur_chn];
        exp_addr = tl_pend[cur_chn] ? tl_addr[cur_chn] : sh_addr[cur_chn];
        exp_len  = (sel > len_t'(`DMA_MAX_RD_DW)) ? len_t'(`DMA_MAX_RD_DW) : sel;
        for (int c = 0; c < 2; c++) begin
            work_now[c] = (sh_len[c] != '0) || tl_pend[c];
            if (cur_chn == chn_t'(c)) begin
                work_after[c] = tl_pend[c] ? (sh_len[c] != '0) : (sh_len[c] != cur_len);
            end else begin
                work_after[c] = work_now[c];
            end
        end
    end

    //////////////////////////////////////////////////
    // shadow state
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            sh_len[0] <= '0;
            sh_len[1] <= '0;
            skip[0]   <= '0;
            skip[1]   <= '0;
            tl_pend   <= '0;
            pos       <= '0;
            exp_tag   <= '0;
            n_tlp     <= '0;
            cur_chn   <= 1'b0;
            last_chn  <= 1'b0;
            last_diff <= 1'b0;
            both_last <= 1'b0;
            both_prev <= 1'b0;
        end else begin
            if (tx_valid) pos <= (pos == 2'd2) ? 2'd0 : pos + 2'd1;
            if (tx_sof) cur_len <= tx_data[9:0];
            if (tx_valid && pos == 2'd1) cur_chn <= tx_data[0];   // id in dw1
            for (int c = 0; c < 2; c++) begin
                if (tx_eof && cur_chn == chn_t'(c)) begin
                    if (tl_pend[c]) begin
                        tl_pend[c] <= 1'b0;   // tail of older descriptor
                    end else begin
                        sh_len[c]  <= sh_len[c] - cur_len;
                        sh_addr[c] <= sh_addr[c] + addr_t'(cur_len);
                    end
                    skip[c] <= '0;
                end else if (tx_eof) begin
                    skip[c] <= work_now[c] ? skip[c] + 2'd1 : 2'd0;
                end
                if (d_val[c] && !d_busy[c] && d_len[c] != '0) begin
                    sh_addr[c] <= d_addr[c];
                    sh_len[c]  <= d_len[c];
                    tl_addr[c] <= sh_addr[c];
                    tl_len[c]  <= sh_len[c];
                    // last chunk granted but not yet on the wire
                    tl_pend[c] <= work_now[c] && !(tx_eof && cur_chn == chn_t'(c));
                end
            end
            if (tx_eof) begin
                exp_tag   <= exp_tag + 1'b1;
                last_chn  <= cur_chn;
                last_diff <= (cur_chn != last_chn);
                both_last <= &work_after;
                both_prev <= both_last;
                if (n_tlp != 2'd2) n_tlp <= n_tlp + 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_idle: assert property (@(posedge clk) $fell(rst) |-> !tx_valid && !chn0_busy && !chn1_busy)
        else flag_error("outputs not idle after reset");
    a_frame: assert property (@(posedge clk) disable iff (rst)
        tx_valid |-> (tx_sof == (pos == 2'd0)) && (tx_eof == (pos == 2'd2)))
        else flag_error("sof or eof out of place in a tlp");
    a_run: assert property (@(posedge clk) disable iff (rst) (pos != 2'd0) |-> tx_valid)
        else flag_error("tlp ended before its third dword");
    a_strb: assert property (@(posedge clk) disable iff (rst) !tx_valid |-> !tx_sof && !tx_eof)
        else flag_error("sof or eof without valid");
    a_dw0: assert property (@(posedge clk) disable iff (rst) tx_sof |-> tx_data[31:10] == '0)
        else flag_error($sformatf("FAIL tx_data dw0 upper got %h exp 0", tx_data[31:10]));
    a_tag: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && pos == 2'd1) |-> tx_data[12:8] == exp_tag)
        else flag_error($sformatf("FAIL tx_data tag got %h exp %h", tx_data[12:8], exp_tag));
    a_dw1: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && pos == 2'd1) |-> tx_data[31:13] == '0 && tx_data[7:1] == '0)
        else flag_error($sformatf("FAIL tx_data dw1 got %h", tx_data));
    a_work: assert property (@(posedge clk) disable iff (rst) tx_eof |-> work_now[cur_chn])
        else flag_error("tlp sent for a channel with no work");
    a_len: assert property (@(posedge clk) disable iff (rst) tx_eof |-> cur_len == exp_len)
        else flag_error($sformatf("FAIL tx_data len got %h exp %h", cur_len, exp_len));
    // byte address, low two bits always clear
    a_addr: assert property (@(posedge clk) disable iff (rst)
        tx_eof |-> tx_data == {exp_addr, 2'b00})
        else flag_error($sformatf("FAIL tx_data addr got %h exp %h",
                                  tx_data, {exp_addr, 2'b00}));
    // waiting channel had its request in at the round before
    a_turn: assert property (@(posedge clk) disable iff (rst)
        (tx_eof && n_tlp == 2'd2 && last_diff && both_last && both_prev)
        |-> cur_chn != last_chn)
        else flag_error($sformatf("FAIL chn id got %h exp %h", cur_chn, !last_chn));
    a_skip0: assert property (@(posedge clk) disable iff (rst)
        (tx_eof && cur_chn && work_now[0]) |-> skip[0] < 2'd2)
        else flag_error("channel 0 starved");
    a_skip1: assert property (@(posedge clk) disable iff (rst)
        (tx_eof && !cur_chn && work_now[1]) |-> skip[1] < 2'd2)
        else flag_error("channel 1 starved");
    a_busy0: assert property (@(posedge clk) disable iff (rst) (sh_len[0] == '0) |-> !chn0_busy)
        else flag_error("FAIL chn0_busy got 1 exp 0");
    a_busy1: assert property (@(posedge clk) disable iff (rst) (sh_len[1] == '0) |-> !chn1_busy)
        else flag_error("FAIL chn1_busy got 1 exp 0");

endmodule

// ==== test/dma_rd_tb.sv ====
/* dma read request testbench */
`include "dma_config.svh"

module dma_rd_tb
    import dma_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_DESC      = 200;
    localparam int BUSY_LIMIT  = 300;      // cycles, per busy period
    localparam int RUN_LIMIT   = 200000;
    localparam int DRAIN_LIMIT = 100;

    logic        clk = 1'b0;
    logic        rst;
    logic [1:0]  d_valid;
    addr_t       d_addr [2];
    len_t        d_len [2];
    logic [1:0]  busy;
    logic [31:0] tx_data;
    logic        tx_valid;
    logic        tx_sof;
    logic        tx_eof;
    logic [31:0] lfsr = 32'he4cc3e80;
    int          sent;
    int          busy_cnt [2];
    int          gap [2];
    int          cycles;
    int          idle;

    always #2 clk = ~clk;   // 4 ns period

    dma_rd_top u_dma_rd_top (
        .clk             (clk),
        .rst             (rst),
        .chn0_desc_valid (d_valid[0]),
        .chn0_desc_addr  (d_addr[0]),
        .chn0_desc_len   (d_len[0]),
        .chn0_busy       (busy[0]),
        .chn1_desc_valid (d_valid[1]),
        .chn1_desc_addr  (d_addr[1]),
        .chn1_desc_len   (d_len[1]),
        .chn1_busy       (busy[1]),
        .tx_data         (tx_data),
        .tx_valid        (tx_valid),
        .tx_sof          (tx_sof),
        .tx_eof          (tx_eof)
    );

    bind dma_rd_top dma_rd_assertions u_chk (.*);

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_errors();
        if (u_dma_rd_top.u_chk.fail_cnt != 0) abort_run("checker assertion failed");
    endtask

    // one falling edge worth of stimulus for a channel
    task automatic drive_chn(input int c);
        d_valid[c] = 1'b0;
        if (busy[c]) begin
            busy_cnt[c]++;
            if (busy_cnt[c] > BUSY_LIMIT) abort_run($sformatf("channel %0d stuck busy", c));
            if (rand_bits(3) == 0) begin
                d_valid[c] = 1'b1;   // strobe while busy, dropped
                d_addr[c]  = addr_t'(rand_bits(`DMA_ADDR_BITS));
                d_len[c]   = len_t'(rand_bits(6));
            end
        end else if (gap[c] > 0) begin
            busy_cnt[c] = 0;
            gap[c]--;
        end else if (sent < N_DESC) begin
            busy_cnt[c] = 0;
            d_valid[c]  = 1'b1;
            d_addr[c]   = addr_t'(rand_bits(`DMA_ADDR_BITS));
            if (rand_bits(4) == 0) begin
                d_len[c] = '0;       // zero length, dropped
            end else begin
                d_len[c] = len_t'(rand_bits(6) % 40 + 1);
                sent++;
            end
            gap[c] = int'(rand_bits(3));
        end
    endtask

    initial begin
        rst         = 1'b1;
        d_valid     = '0;
        d_addr[0]   = '0;
        d_addr[1]   = '0;
        d_len[0]    = '0;
        d_len[1]    = '0;
        sent        = 0;
        busy_cnt[0] = 0;
        busy_cnt[1] = 0;
        gap[0]      = 0;
        gap[1]      = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        cycles = 0;
        while (sent < N_DESC) begin
            @(negedge clk);
            check_errors();
            cycles++;
            if (cycles > RUN_LIMIT) abort_run("descriptors not all sent in time");
            drive_chn(0);
            drive_chn(1);
        end

        // let the last tlps leave
        @(negedge clk);
        d_valid = '0;
        idle    = 0;
        cycles  = 0;
        while (idle < 8) begin
            @(negedge clk);
            check_errors();
            idle = (busy != 0 || tx_valid) ? 0 : idle + 1;
            cycles++;
            if (cycles > DRAIN_LIMIT) abort_run("stream did not drain");
        end

        if (u_dma_rd_top.u_chk.fail_cnt != 0) begin
            abort_run("checker assertion failed");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== verilog/dma_chn_arb.sv ====
/* transmit endpoint arbiter */

module dma_chn_arb
    import dma_pkg::*;
(
    input  logic clk,
    input  logic rst,

    // channel 0
    input  logic chn0_reqep,
    input  logic chn0_drvn,   // builder busy with chn0 tlp
    output logic chn0_trn,    // one-cycle grant

    // channel 1
    input  logic chn1_reqep,
    input  logic chn1_drvn,
    output logic chn1_trn
);

    arb_state_e state;
    logic       turn;   // set gives channel 1 the first look

    //////////////////////////////////////////////////
    // grant fsm
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ARB_INIT;
            turn     <= 1'b0;
            chn0_trn <= 1'b0;
            chn1_trn <= 1'b0;
        end else begin
            chn0_trn <= 1'b0;   // strobes last one cycle
            chn1_trn <= 1'b0;

            case (state)
                ARB_INIT: begin
                    state <= ARB_GRANT;
                end

                ARB_GRANT: begin
                    // endpoint must be free on both sides
                    if (!chn0_drvn && !chn1_drvn) begin
                        if (chn1_reqep && turn) begin
                            chn1_trn <= 1'b1;
                        end else if (chn0_reqep) begin
                            chn0_trn <= 1'b1;
                        end
                        turn  <= ~turn;   // flips even on an empty round
                        state <= ARB_SETTLE;
                    end
                end

                ARB_SETTLE: state <= ARB_GRANT;   // builder picks up drvn here

                default: state <= ARB_INIT;
            endcase
        end
    end

endmodule

// ==== verilog/dma_chn_req.sv ====
/* channel descriptor decode and chunking */
`include "dma_config.svh"

module dma_chn_req
    import dma_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // descriptor in
    input  logic  desc_valid,   // single-cycle strobe
    input  addr_t desc_addr,
    input  len_t  desc_len,
    output logic  busy,

    // to arbiter and builder
    output logic  reqep,        // chunk pending
    output addr_t chunk_addr,
    output len_t  chunk_len,
    input  logic  trn           // grant of current chunk
);

    //////////////////////////////////////////////////
    // remaining work of the active descriptor
    //////////////////////////////////////////////////

    addr_t rem_addr;     // next dword to request
    len_t  rem_len;      // dwords still to request
    logic  desc_accept;

    // new descriptor only when idle, zero length dropped
    assign desc_accept = desc_valid && !busy && (desc_len != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rem_len <= '0;
        end else if (desc_accept) begin
            rem_addr <= desc_addr;
            rem_len  <= desc_len;
        end else if (trn && busy) begin
            // step past the granted chunk
            rem_addr <= rem_addr + addr_t'(chunk_len);
            rem_len  <= rem_len - chunk_len;
        end
    end

    //////////////////////////////////////////////////
    // chunk offered to the arbiter
    //////////////////////////////////////////////////

    always_comb begin
        if (rem_len > len_t'(`DMA_MAX_RD_DW)) begin
            chunk_len = len_t'(`DMA_MAX_RD_DW);   // full size read
        end else begin
            chunk_len = rem_len;                  // tail of descriptor
        end
    end

    assign chunk_addr = rem_addr;

    // busy drops once the last chunk was granted
    assign busy  = (rem_len != '0);
    assign reqep = busy;   // request whenever work is left

endmodule

// ==== verilog/dma_config.svh ====
/* dma read engine configuration */
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

//////////////////////////////////////////////////
// request sizing
//////////////////////////////////////////////////

// largest memory-read request, in dwords
`define DMA_MAX_RD_DW 16

//////////////////////////////////////////////////
// field widths
//////////////////////////////////////////////////

`define DMA_LEN_BITS  10   // dword count, fits tlp length field
`define DMA_TAG_BITS  5    // 32 tags outstanding max
`define DMA_ADDR_BITS 30   // dword address, 32-bit byte space

`endif

// ==== verilog/dma_pkg.sv ====
/* dma read engine types */
`include "dma_config.svh"

package dma_pkg;

    typedef logic [`DMA_ADDR_BITS-1:0] addr_t;  // dword address
    typedef logic [`DMA_LEN_BITS-1:0]  len_t;   // length in dwords
    typedef logic [`DMA_TAG_BITS-1:0]  tag_t;   // rolling request tag
    typedef logic                      chn_t;   // channel id

    // arbiter fsm
    typedef enum logic [1:0] {
        ARB_INIT,    // one pass after reset
        ARB_GRANT,   // evaluate requests when endpoint free
        ARB_SETTLE   // one cycle hold after a decision
    } arb_state_e;

    // header builder fsm, names the dword on the stream
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_DW0,
        TX_DW1,
        TX_DW2
    } tx_state_e;

endpackage

// ==== verilog/dma_rd_top.sv ====
/* two-channel dma read request top */

module dma_rd_top
    import dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // channel 0 descriptors
    input  logic        chn0_desc_valid,
    input  addr_t       chn0_desc_addr,
    input  len_t        chn0_desc_len,
    output logic        chn0_busy,

    // channel 1 descriptors
    input  logic        chn1_desc_valid,
    input  addr_t       chn1_desc_addr,
    input  len_t        chn1_desc_len,
    output logic        chn1_busy,

    // read request stream
    output logic [31:0] tx_data,
    output logic        tx_valid,
    output logic        tx_sof,
    output logic        tx_eof
);

    // channel to arbiter and builder
    logic  chn0_reqep, chn1_reqep;
    addr_t chn0_addr, chn1_addr;
    len_t  chn0_len, chn1_len;
    // grants and endpoint ownership
    logic  chn0_trn, chn1_trn;
    logic  chn0_drvn, chn1_drvn;

    //////////////////////////////////////////////////
    // channels
    //////////////////////////////////////////////////

    dma_chn_req u_chn0 (
        .clk        (clk),
        .rst        (rst),
        .desc_valid (chn0_desc_valid),
        .desc_addr  (chn0_desc_addr),
        .desc_len   (chn0_desc_len),
        .busy       (chn0_busy),
        .reqep      (chn0_reqep),
        .chunk_addr (chn0_addr),
        .chunk_len  (chn0_len),
        .trn        (chn0_trn)
    );

    dma_chn_req u_chn1 (
        .clk        (clk),
        .rst        (rst),
        .desc_valid (chn1_desc_valid),
        .desc_addr  (chn1_desc_addr),
        .desc_len   (chn1_desc_len),
        .busy       (chn1_busy),
        .reqep      (chn1_reqep),
        .chunk_addr (chn1_addr),
        .chunk_len  (chn1_len),
        .trn        (chn1_trn)
    );

    //////////////////////////////////////////////////
    // arbiter and header builder
    //////////////////////////////////////////////////

    dma_chn_arb u_arb (
        .clk        (clk),
        .rst        (rst),
        .chn0_reqep (chn0_reqep),
        .chn0_drvn  (chn0_drvn),
        .chn0_trn   (chn0_trn),
        .chn1_reqep (chn1_reqep),
        .chn1_drvn  (chn1_drvn),
        .chn1_trn   (chn1_trn)
    );

    dma_tlp_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .chn0_trn   (chn0_trn),
        .chn0_addr  (chn0_addr),
        .chn0_len   (chn0_len),
        .chn0_drvn  (chn0_drvn),
        .chn1_trn   (chn1_trn),
        .chn1_addr  (chn1_addr),
        .chn1_len   (chn1_len),
        .chn1_drvn  (chn1_drvn),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_sof     (tx_sof),
        .tx_eof     (tx_eof)
    );

endmodule

// ==== verilog/dma_tlp_tx.sv ====
/* memory-read header builder */

module dma_tlp_tx
    import dma_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // channel 0 chunk
    input  logic        chn0_trn,
    input  addr_t       chn0_addr,
    input  len_t        chn0_len,
    output logic        chn0_drvn,

    // channel 1 chunk
    input  logic        chn1_trn,
    input  addr_t       chn1_addr,
    input  len_t        chn1_len,
    output logic        chn1_drvn,

    // 32-bit stream to endpoint, no back-pressure
    output logic [31:0] tx_data,
    output logic        tx_valid,
    output logic        tx_sof,
    output logic        tx_eof
);

    // mrd32, 3dw header, no data
    localparam logic [7:0] MRD32_FMT_TYPE = 8'h00;

    tx_state_e state;
    addr_t     lat_addr;   // chunk latched at grant
    len_t      lat_len;
    chn_t      lat_chn;
    tag_t      tag;        // tag of the tlp on the wire

    //////////////////////////////////////////////////
    // latch and walk the three dwords
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TX_IDLE;
            tag   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (chn1_trn) begin
                        lat_addr <= chn1_addr;
                        lat_len  <= chn1_len;
                        lat_chn  <= 1'b1;
                        state    <= TX_DW0;
                    end else if (chn0_trn) begin
                        lat_addr <= chn0_addr;
                        lat_len  <= chn0_len;
                        lat_chn  <= 1'b0;
                        state    <= TX_DW0;
                    end
                end
                TX_DW0: state <= TX_DW1;
                TX_DW1: state <= TX_DW2;
                TX_DW2: begin
                    tag   <= tag + 1'b1;   // wraps at 32
                    state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // stream outputs
    //////////////////////////////////////////////////

    always_comb begin
        case (state)
            TX_DW0:  tx_data = {MRD32_FMT_TYPE, 14'd0, lat_len};  // 16 sent as 16
            TX_DW1:  tx_data = {19'd0, tag, 7'd0, lat_chn};       // tag at 12:8
            TX_DW2:  tx_data = {lat_addr, 2'b00};                 // byte address
            default: tx_data = '0;
        endcase
    end

    assign tx_valid = (state != TX_IDLE);
    assign tx_sof   = (state == TX_DW0);
    assign tx_eof   = (state == TX_DW2);

    // holds off the arbiter for the owning channel
    assign chn0_drvn = tx_valid && (lat_chn == 1'b0);
    assign chn1_drvn = tx_valid && (lat_chn == 1'b1);

endmodule
